// ==== build.f ====
+incdir+include
design/mips_pkg.sv
design/pipeStage.sv
design/fetchUnit.sv
design/regFile.sv
design/decodeUnit.sv
design/executeUnit.sv
design/memWriteback.sv
design/mipsCore.sv
dv/tbMipsCore.sv

// ==== design/decodeUnit.sv ====
`include "mips_defines.svh"

module decodeUnit (
	input logic clk,
	input logic rstN,
	input mips_pkg::ifId_t ifId,
	input mips_pkg::regAddr_t exDest,
	input logic exRegWrite,
	input logic exMemRead,
	input mips_pkg::regAddr_t memDest,
	input logic memRegWrite,
	input logic memMemRead,
	input mips_pkg::regAddr_t wbDest,
	input logic wbEn,
	input mips_pkg::word_t wbData,
	output mips_pkg::idEx_t idEx,
	output logic stall,
	output logic redirect,
	output logic flushIfId,
	output mips_pkg::word_t branchTarget
);
	import mips_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	word_t imm;
	word_t rsData;
	word_t rtData;
	ctrl_t ctrl;
	logic isBeq;
	logic usesRs;
	logic usesRt;
	logic exMatch;
	logic memMatch;
	logic loadUse;
	logic branchWait;

	assign opcode = ifId.instr[31:26];
	assign funct = ifId.instr[5:0];
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign imm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

	regFile u_regFile (
		.clk(clk),
		.rstN(rstN),
		.rsAddr(rs),
		.rtAddr(rt),
		.wrAddr(wbDest),
		.wrEn(wbEn),
		.wrData(wbData),
		.rsData(rsData),
		.rtData(rtData)
	);

	// Control decode, unknown encodings fall out as all-zero
	always_comb begin
		ctrl = '0;
		isBeq = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (funct)
					`FN_ADD: ctrl.aluOp = ADD;
					`FN_SUB: ctrl.aluOp = SUB;
					`FN_AND: ctrl.aluOp = AND;
					`FN_OR: ctrl.aluOp = OR;
					`FN_SLT: ctrl.aluOp = SLT;
					default: ctrl = '0;
				endcase
			end
			`OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			`OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			`OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			// beq resolves here and carries no control further down
			`OP_BEQ: isBeq = 1'b1;
			default: ctrl = '0;
		endcase
	end

	// Which source fields are really read
	assign usesRs = ctrl.regWrite | ctrl.memWrite | isBeq;
	assign usesRt = ctrl.regDst | ctrl.memWrite | isBeq;

	assign exMatch = (exDest != '0) &&
		((usesRs && exDest == rs) || (usesRt && exDest == rt));
	assign memMatch = (memDest != '0) &&
		((usesRs && memDest == rs) || (usesRt && memDest == rt));

	// Load in EX, its data only exists after MEM
	assign loadUse = exMemRead && exMatch;
	// beq compares register file values, so wait until the producer reaches MEM/WB
	// Both ALU results and loads in EX/MEM are still invisible here
	assign branchWait = isBeq &&
		((exRegWrite && exMatch) || ((memRegWrite || memMemRead) && memMatch));
	assign stall = loadUse || branchWait;

	assign branchTarget = ifId.pcPlus4 + {imm[`DATA_WIDTH-3:0], 2'b00};
	assign redirect = isBeq && (rsData == rtData) && !stall;
	// Kill the one wrong-path fetch behind a taken beq
	assign flushIfId = redirect;

	// Bubble into ID/EX while stalled
	always_comb begin
		if (stall) begin
			idEx = '0;
		end else begin
			idEx.ctrl = ctrl;
			idEx.rs = rs;
			idEx.rt = rt;
			idEx.rd = rd;
			idEx.rsData = rsData;
			idEx.rtData = rtData;
			idEx.imm = imm;
		end
	end

endmodule

// ==== design/executeUnit.sv ====
`include "mips_defines.svh"

module executeUnit (
	input mips_pkg::idEx_t idEx,
	input logic memFwdEn,
	input mips_pkg::regAddr_t memFwdDest,
	input mips_pkg::word_t memFwdData,
	input logic wbFwdEn,
	input mips_pkg::regAddr_t wbFwdDest,
	input mips_pkg::word_t wbFwdData,
	output mips_pkg::exMem_t exMem
);
	import mips_pkg::*;

	word_t opA;
	word_t fwdRt;
	word_t opB;
	word_t aluResult;

	// Youngest producer wins
	// $zero is never forwarded
	function automatic word_t fwdSelect(
		input regAddr_t src,
		input word_t regVal,
		input logic memEn,
		input regAddr_t memDest,
		input word_t memData,
		input logic wbEn,
		input regAddr_t wbDest,
		input word_t wbData
	);
		word_t sel;
		sel = regVal;
		if (src != '0 && memEn && memDest == src) begin
			sel = memData;
		end else if (src != '0 && wbEn && wbDest == src) begin
			sel = wbData;
		end
		return sel;
	endfunction

	assign opA = fwdSelect(idEx.rs, idEx.rsData, memFwdEn, memFwdDest, memFwdData,
		wbFwdEn, wbFwdDest, wbFwdData);
	assign fwdRt = fwdSelect(idEx.rt, idEx.rtData, memFwdEn, memFwdDest, memFwdData,
		wbFwdEn, wbFwdDest, wbFwdData);
	// Immediate for addi, lw and sw
	assign opB = idEx.ctrl.aluSrc ? idEx.imm : fwdRt;

	always_comb begin
		case (idEx.ctrl.aluOp)
			ADD: aluResult = opA + opB;
			SUB: aluResult = opA - opB;
			AND: aluResult = opA & opB;
			OR: aluResult = opA | opB;
			// signed compare
			SLT: aluResult = {{(`DATA_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluResult = opA + opB;
		endcase
	end

	assign exMem.regWrite = idEx.ctrl.regWrite;
	assign exMem.memRead = idEx.ctrl.memRead;
	assign exMem.memWrite = idEx.ctrl.memWrite;
	assign exMem.memToReg = idEx.ctrl.memToReg;
	// rd for R-type and rt otherwise
	assign exMem.dest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
	assign exMem.aluResult = aluResult;
	assign exMem.storeData = fwdRt;

endmodule

// ==== design/fetchUnit.sv ====
`include "mips_defines.svh"

module fetchUnit (
	input logic clk,
	input logic rstN,
	input logic stall,
	input logic redirect,
	input mips_pkg::word_t branchTarget,
	input logic imemWe,
	input logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
	input mips_pkg::word_t imemData,
	output mips_pkg::ifId_t ifId
);
	import mips_pkg::*;

	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

	word_t imem [`IMEM_DEPTH];
	word_t pc;
	word_t pcPlus4;
	word_t pcOffset;
	word_t instr;

	// Program load, only honoured while the core sits in reset
	always_ff @(posedge clk) begin
		if (!rstN && imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// Redirect is never raised together with stall
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `TEXT_BASE;
		end else if (redirect) begin
			pc <= branchTarget;
		end else if (!stall) begin
			pc <= pcPlus4;
		end
	end

	assign pcPlus4 = pc + 32'd4;
	// Strip the text base to get a byte offset into program memory
	assign pcOffset = pc - `TEXT_BASE;

	// Past the end of memory reads as a nop
	always_comb begin
		if (pcOffset[`DATA_WIDTH-1:2] < `IMEM_DEPTH) begin
			instr = imem[pcOffset[IMEM_AW+1:2]];
		end else begin
			instr = '0;
		end
	end

	assign ifId.instr = instr;
	assign ifId.pcPlus4 = pcPlus4;

endmodule

// ==== design/memWriteback.sv ====
`include "mips_defines.svh"

module memWriteback (
	input logic clk,
	input mips_pkg::exMem_t exMem,
	output mips_pkg::word_t loadData
);
	import mips_pkg::*;

	localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

	word_t dmem [`DMEM_DEPTH];
	logic [DMEM_AW-1:0] wordIdx;

	// Word address, upper bits dropped so it wraps
	assign wordIdx = exMem.aluResult[DMEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (exMem.memWrite) begin
			dmem[wordIdx] <= exMem.storeData;
		end
	end

	// Zero for anything that is not a load
	assign loadData = exMem.memRead ? dmem[wordIdx] : '0;

endmodule

// ==== design/mipsCore.sv ====
`include "mips_defines.svh"

module mipsCore (
	input logic clk,
	input logic rstN,
	input logic imemWe,
	input logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr,
	input mips_pkg::word_t imemData,
	output logic wbValid,
	output mips_pkg::regAddr_t wbReg,
	output mips_pkg::word_t wbData
);
	import mips_pkg::*;

	ifId_t ifIdD;
	ifId_t ifIdQ;
	idEx_t idExD;
	idEx_t idExQ;
	exMem_t exMemD;
	exMem_t exMemQ;
	memWb_t memWbD;
	memWb_t memWbQ;
	word_t loadData;
	word_t branchTarget;
	logic stall;
	logic redirect;
	logic flushIfId;

	fetchUnit u_fetch (
		.clk(clk),
		.rstN(rstN),
		.stall(stall),
		.redirect(redirect),
		.branchTarget(branchTarget),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.ifId(ifIdD)
	);

	// Held on a stall, squashed on a taken branch
	pipeStage #(.payload_t(ifId_t)) ifIdReg (
		.clk(clk),
		.rstN(rstN),
		.hold(stall),
		.flush(flushIfId),
		.d(ifIdD),
		.q(ifIdQ)
	);

	// Hazard inputs come from the EX output and the EX/MEM register
	decodeUnit u_decode (
		.clk(clk),
		.rstN(rstN),
		.ifId(ifIdQ),
		.exDest(exMemD.dest),
		.exRegWrite(exMemD.regWrite),
		.exMemRead(exMemD.memRead),
		.memDest(exMemQ.dest),
		.memRegWrite(exMemQ.regWrite),
		.memMemRead(exMemQ.memRead),
		.wbDest(memWbQ.dest),
		.wbEn(memWbQ.regWrite),
		.wbData(wbData),
		.idEx(idExD),
		.stall(stall),
		.redirect(redirect),
		.flushIfId(flushIfId),
		.branchTarget(branchTarget)
	);

	// Decode already supplies the bubble, so no hold or flush here
	pipeStage #(.payload_t(idEx_t)) idExReg (
		.clk(clk),
		.rstN(rstN),
		.hold(1'b0),
		.flush(1'b0),
		.d(idExD),
		.q(idExQ)
	);

	executeUnit u_execute (
		.idEx(idExQ),
		.memFwdEn(exMemQ.regWrite),
		.memFwdDest(exMemQ.dest),
		.memFwdData(exMemQ.aluResult),
		.wbFwdEn(memWbQ.regWrite),
		.wbFwdDest(memWbQ.dest),
		.wbFwdData(wbData),
		.exMem(exMemD)
	);

	pipeStage #(.payload_t(exMem_t)) exMemReg (
		.clk(clk),
		.rstN(rstN),
		.hold(1'b0),
		.flush(1'b0),
		.d(exMemD),
		.q(exMemQ)
	);

	memWriteback u_memWb (
		.clk(clk),
		.exMem(exMemQ),
		.loadData(loadData)
	);

	// MEM/WB payload built from EX/MEM plus the load data
	assign memWbD.regWrite = exMemQ.regWrite;
	assign memWbD.memToReg = exMemQ.memToReg;
	assign memWbD.dest = exMemQ.dest;
	assign memWbD.aluResult = exMemQ.aluResult;
	assign memWbD.loadData = loadData;

	pipeStage #(.payload_t(memWb_t)) memWbReg (
		.clk(clk),
		.rstN(rstN),
		.hold(1'b0),
		.flush(1'b0),
		.d(memWbD),
		.q(memWbQ)
	);

	// Writeback select, also the forwarding and observation value
	assign wbData = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;
	assign wbReg = memWbQ.dest;
	// Writes to $zero retire silently
	assign wbValid = memWbQ.regWrite && (memWbQ.dest != '0);

endmodule

// ==== design/mips_pkg.sv ====
`include "mips_defines.svh"

package mips_pkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

	// ADD is zero so an all-zero control word is harmless
	typedef enum logic [2:0] {
		ADD = 3'd0,
		SUB = 3'd1,
		AND = 3'd2,
		OR = 3'd3,
		SLT = 3'd4
	} aluOp_t;

	// All zero means no-operation
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc;
		logic regDst;
		aluOp_t aluOp;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pcPlus4;
	} ifId_t;

	typedef struct packed {
		ctrl_t ctrl;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		word_t rsData;
		word_t rtData;
		word_t imm;
	} idEx_t;

	// Store data is the forwarded rt value
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		regAddr_t dest;
		word_t aluResult;
		word_t storeData;
	} exMem_t;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		regAddr_t dest;
		word_t aluResult;
		word_t loadData;
	} memWb_t;

endpackage

// ==== design/pipeStage.sv ====
module pipeStage #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rstN,
	input logic hold,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	// Zero payload is a bubble for every stage struct
	// Flush beats hold, so a squashed slot never survives a stall
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
		// Otherwise keep the held payload
	end

endmodule

// ==== design/regFile.sv ====
module regFile (
	input logic clk,
	input logic rstN,
	input mips_pkg::regAddr_t rsAddr,
	input mips_pkg::regAddr_t rtAddr,
	input mips_pkg::regAddr_t wrAddr,
	input logic wrEn,
	input mips_pkg::word_t wrData,
	output mips_pkg::word_t rsData,
	output mips_pkg::word_t rtData
);
	import mips_pkg::*;

	localparam int NUM_REGS = 2 ** $bits(regAddr_t);

	word_t regs [NUM_REGS];
	logic wrLive;

	// $zero never takes a write, so it stays at its reset value
	assign wrLive = wrEn && (wrAddr != '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-first bypass, decode sees the MEM/WB value this cycle
	assign rsData = (wrLive && wrAddr == rsAddr) ? wrData : regs[rsAddr];
	assign rtData = (wrLive && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

// ==== include/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// R-type word, operand order as in assembly: rd, rs, rt
function automatic logic [31:0] rType(input logic [5:0] fn, input int rd, input int rs,
	input int rt);
	return {`OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
endfunction

// I-type word, operand order as in assembly: rt, rs, imm
function automatic logic [31:0] iType(input logic [5:0] op, input int rt, input int rs,
	input int imm);
	return {op, rs[4:0], rt[4:0], imm[15:0]};
endfunction

localparam int NUM_TESTS = 5;

// Per test: program length, expected writebacks, writebacks seen before a mid-run reset
localparam int PROG_LEN [NUM_TESTS] = '{6, 4, 6, 11, 5};
localparam int EXP_LEN [NUM_TESTS] = '{6, 4, 5, 5, 3};
localparam int RESET_AFTER [NUM_TESTS] = '{0, 0, 0, 0, 1};

// All programs back to back, each one starts at the text base
localparam int PROG_TOTAL = 32;
localparam logic [31:0] PROG_WORDS [PROG_TOTAL] = '{
	// Chained arithmetic
	iType(`OP_ADDI, 1, 0, 5),
	iType(`OP_ADDI, 2, 1, 3),
	rType(`FN_ADD, 3, 2, 1),
	rType(`FN_SUB, 4, 3, 1),
	rType(`FN_AND, 5, 4, 3),
	rType(`FN_OR, 6, 5, 1),
	// Signed compare, -7 against 3
	iType(`OP_ADDI, 1, 0, -7),
	iType(`OP_ADDI, 2, 0, 3),
	rType(`FN_SLT, 3, 1, 2),
	rType(`FN_SLT, 4, 2, 1),
	// Store then load back, add right behind the load
	iType(`OP_ADDI, 1, 0, 'h1234),
	iType(`OP_ADDI, 2, 0, 8),
	iType(`OP_SW, 1, 2, 4),
	iType(`OP_LW, 3, 2, 4),
	rType(`FN_ADD, 4, 3, 3),
	iType(`OP_LW, 5, 0, 12),
	// Branches
	iType(`OP_ADDI, 1, 0, 4),
	iType(`OP_ADDI, 2, 0, 4),
	iType(`OP_BEQ, 2, 1, 2),      // taken, skips the next two
	iType(`OP_ADDI, 3, 0, 1),
	iType(`OP_ADDI, 3, 0, 2),
	iType(`OP_ADDI, 4, 0, 9),
	iType(`OP_BEQ, 4, 1, 1),      // 4 vs 9, falls through
	iType(`OP_ADDI, 5, 0, 7),
	iType(`OP_BEQ, 0, 0, 1),      // always taken
	iType(`OP_ADDI, 6, 0, 1),
	iType(`OP_ADDI, 7, 5, 1),
	// Register zero, restarted by a mid-run reset
	iType(`OP_ADDI, 0, 0, 5),
	iType(`OP_ADDI, 1, 0, 3),
	rType(`FN_ADD, 0, 1, 1),
	rType(`FN_ADD, 2, 0, 1),
	rType(`FN_OR, 3, 0, 0)
};

// Expected writebacks in retirement order, register and data columns
localparam int EXP_TOTAL = 23;
localparam logic [31:0] EXP_REG [EXP_TOTAL] = '{
	1, 2, 3, 4, 5, 6,
	1, 2, 3, 4,
	1, 2, 3, 4, 5,
	1, 2, 4, 5, 7,
	1, 2, 3
};
localparam logic [31:0] EXP_DATA [EXP_TOTAL] = '{
	32'd5, 32'd8, 32'd13, 32'd8, 32'd8, 32'd13,
	32'hFFFF_FFF9, 32'd3, 32'd1, 32'd0,
	32'h1234, 32'd8, 32'h1234, 32'h2468, 32'h1234,
	32'd4, 32'd4, 32'd9, 32'd7, 32'd8,
	32'd3, 32'd3, 32'd0
};

function automatic string testName(input int t);
	case (t)
		0: return "arith_chain";
		1: return "signed_slt";
		2: return "store_load";
		3: return "branches";
		4: return "zero_and_reset";
		default: return "unknown";
	endcase
endfunction

`endif

// ==== dv/tbMipsCore.sv ====
`include "mips_defines.svh"

module tbMipsCore;
	import mips_pkg::*;

	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);
	// Cycles watched for stray writebacks after each test
	localparam int QUIET_CYCLES = 8;

	logic clk;
	logic rstN;
	logic imemWe;
	logic [IMEM_AW-1:0] imemAddr;
	word_t imemData;
	logic wbValid;
	regAddr_t wbReg;
	word_t wbData;

	`include "tb_programs.svh"

	mipsCore u_dut (
		.clk(clk),
		.rstN(rstN),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Offsets of a test inside the flat tables
	function automatic int progBase(input int t);
		int base;
		base = 0;
		for (int i = 0; i < t; i++) begin
			base += PROG_LEN[i];
		end
		return base;
	endfunction

	function automatic int expBase(input int t);
		int base;
		base = 0;
		for (int i = 0; i < t; i++) begin
			base += EXP_LEN[i];
		end
		return base;
	endfunction

	// Four cycles per instruction plus pipeline fill
	function automatic int runLimit(input int t);
		return 4 * PROG_LEN[t] + 20;
	endfunction

	// Load, reset and drain cycles on top of the run limit
	function automatic int testBudget(input int t);
		int runs;
		runs = (RESET_AFTER[t] > 0) ? 2 : 1;
		return `IMEM_DEPTH + 12 + QUIET_CYCLES + runs * runLimit(t);
	endfunction

	function automatic int watchdogCycles();
		int total;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total += testBudget(t);
		end
		return total;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected 0x%08h, actual 0x%08h", what, expected, actual);
			$display("Testbench failed");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// Program words followed by zero fill
	task automatic loadProgram(input int t);
		int base;
		base = progBase(t);
		for (int a = 0; a < `IMEM_DEPTH; a++) begin
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= a[IMEM_AW-1:0];
			imemData <= (a < PROG_LEN[t]) ? PROG_WORDS[base + a] : 32'h0;
		end
		@(posedge clk);
		imemWe <= 1'b0;
	endtask

	// Compare the first count writebacks against the table
	task automatic collectWritebacks(input int t, input int count);
		int got;
		int cycles;
		int idx;
		got = 0;
		cycles = 0;
		while (got < count) begin
			@(negedge clk);
			cycles++;
			if (wbValid) begin
				idx = expBase(t) + got;
				checkValue($sformatf("%s writeback %0d register", testName(t), got),
					EXP_REG[idx], 32'(wbReg));
				checkValue($sformatf("%s writeback %0d data", testName(t), got),
					EXP_DATA[idx], wbData);
				got++;
			end else if (cycles > runLimit(t)) begin
				$display("Test %s timed out: only %0d of %0d writebacks after %0d cycles",
					testName(t), got, count, cycles);
				$display("Testbench failed");
				$fatal(1, "Per-test timeout");
			end
		end
	endtask

	// Two cycles of reset in the middle of a run
	task automatic pulseReset(input int t);
		@(posedge clk);
		rstN <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		checkValue($sformatf("%s wbValid during reset", testName(t)), 32'd0, 32'(wbValid));
		@(posedge clk);
		rstN <= 1'b1;
	endtask

	// Flushed or skipped work must never retire late
	task automatic expectIdle(input int t);
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			checkValue($sformatf("%s extra writeback", testName(t)), 32'd0, 32'(wbValid));
		end
	endtask

	task automatic runTest(input int t);
		@(posedge clk);
		rstN <= 1'b0;
		loadProgram(t);
		repeat (2) @(posedge clk);
		rstN <= 1'b1;
		if (RESET_AFTER[t] > 0) begin
			collectWritebacks(t, RESET_AFTER[t]);
			pulseReset(t);
		end
		collectWritebacks(t, EXP_LEN[t]);
		expectIdle(t);
	endtask

	initial begin
		int limit;
		limit = watchdogCycles();
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles before all tests finished", limit);
		$display("Testbench failed");
		$fatal(1, "Global timeout");
	end

	initial begin
		rstN = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			runTest(t);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== include/mips_defines.svh ====
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Machine word and register index widths
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

// Byte address where the first instruction lives
`define TEXT_BASE 32'h0040_0000

// Memory sizes, in words
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64

// Primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00
`define OP_BEQ 6'h04
`define OP_ADDI 6'h08
`define OP_LW 6'h23
`define OP_SW 6'h2B

// R-type function codes, instr[5:0]
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR 6'h25
`define FN_SLT 6'h2A

`endif

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tbMipsCore -f build.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "Testbench failed" sim.log; then
	echo "Simulation reported errors, see sim.log"
	exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
	echo "Simulation ended without a result, see sim.log"
	exit 1
fi
echo "Simulation clean"
